// ==== verilog.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/load_align.sv
hdl/store_align.sv
hdl/cache_ways.sv
hdl/cache_ctrl.sv
hdl/dcache.sv
verif/tb_clock.sv
verif/mem_model.sv
verif/tb_dcache.sv

// ==== verif/tb_dcache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import cache_pkg::*;

    logic        clk;
    logic        rst_n;
    logic [31:0] address;
    logic        load;
    load_type_t  load_type;
    logic        store;
    store_type_t store_type;
    logic [31:0] store_data;
    logic        busy;
    logic        done;
    logic [31:0] load_data;
    logic        load_misaligned;
    logic        load_unknown_type;
    logic        store_misaligned;
    logic        store_unknown_type;
    logic [31:0] m_address;
    logic [3:0]  m_burstcount;
    logic        m_read;
    logic        m_write;
    logic [31:0] m_writedata;
    logic [3:0]  m_byteenable;
    logic        m_waitrequest;
    logic [31:0] m_readdata;
    logic        m_readdatavalid;

    logic [31:0] mirror [logic [31:0]];
    int          read_cmds;
    int          write_beats;
    logic [31:0] last_read_addr;
    logic [3:0]  last_read_burst;
    logic [3:0]  last_be;
    logic [31:0] got_data;
    logic [3:0]  got_flags;
    int          r0;
    int          w0;

    tb_clock clock_i (.clk(clk), .rst_n(rst_n));

    mem_model mem_i (.*);

    dcache dcache_i (.*);

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, act);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0d ns while waiting for %s", $time, what);
        $display("sim failed");
        $fatal(1);
    endtask

    // Bus activity as seen by the memory
    always @(posedge clk) begin
        if (m_read && !m_waitrequest) begin
            read_cmds       <= read_cmds + 1;
            last_read_addr  <= m_address;
            last_read_burst <= m_burstcount;
        end
        if (m_write && !m_waitrequest) begin
            write_beats <= write_beats + 1;
            last_be     <= m_byteenable;
        end
    end

    assert property (@(posedge clk) !rst_n |-> !busy && !done && !m_read && !m_write)
        else fail_value("busy,done,m_read,m_write", 0,
                        {$sampled(busy), $sampled(done), $sampled(m_read), $sampled(m_write)});

    assert property (@(posedge clk) disable iff (!rst_n)
        (m_read || m_write) |-> m_burstcount == (m_address[31] ? 4'd1 : 4'd8))
        else fail_value("m_burstcount", $sampled(m_address[31]) ? 1 : 8, $sampled(m_burstcount));

    assert property (@(posedge clk) disable iff (!rst_n)
        (m_read || m_write) && !m_address[31] |-> m_address[4:0] == 5'd0)
        else fail_value("m_address", {$sampled(m_address[31:5]), 5'd0}, $sampled(m_address));

    assert property (@(posedge clk) disable iff (!rst_n)
        m_write && !m_address[31] |-> m_byteenable == 4'hf)
        else fail_value("m_byteenable", 4'hf, $sampled(m_byteenable));

    function automatic logic [31:0] mirror_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (mirror.exists(a))
            return mirror[a];
        return a ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] w, input logic [1:0] off,
                                                input logic [2:0] t);
        logic [7:0]  b;
        logic [15:0] h;
        b = w >> (8 * off);
        h = off[1] ? w[31:16] : w[15:0];
        case (t)
            3'd0: return {{24{b[7]}}, b};
            3'd1: return {{16{h[15]}}, h};
            3'd4: return {24'd0, b};
            3'd5: return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic [3:0] mask_of(input logic [1:0] off, input logic [1:0] t);
        case (t)
            2'd0: return 4'b0001 << off;
            2'd1: return off[0] ? 4'b0000 : (off[1] ? 4'b1100 : 4'b0011);
            2'd2: return off == 2'd0 ? 4'b1111 : 4'b0000;
            default: return 4'b0000;
        endcase
    endfunction

    // One request from issue to done, flags returned as lm, lu, sm, su
    task automatic access(input logic is_load, input logic [31:0] addr,
                          input logic [2:0] lt, input logic [1:0] st, input logic [31:0] data);
        int t;
        @(negedge clk);
        address    = addr;
        load       = is_load;
        store      = !is_load;
        load_type  = load_type_t'(lt);
        store_type = store_type_t'(st);
        store_data = data;
        t = 0;
        while (busy) begin
            @(negedge clk);
            t++;
            if (t > 300)
                timeout_fail("request acceptance");
        end
        @(negedge clk);
        load  = 1'b0;
        store = 1'b0;
        t = 0;
        while (!done) begin
            @(negedge clk);
            t++;
            if (t > 600)
                timeout_fail("done");
        end
        got_data  = load_data;
        got_flags = {load_misaligned, load_unknown_type, store_misaligned, store_unknown_type};
    endtask

    task automatic check_load(input logic [31:0] addr, input logic [2:0] lt);
        logic       mis;
        logic       unk;
        logic [31:0] exp;
        unk = lt == 3'd3 || lt > 3'd5;
        mis = !unk && ((lt[1:0] == 2'd1 && addr[0]) || (lt == 3'd2 && addr[1:0] != 2'd0));
        exp = expect_load(mirror_word(addr), addr[1:0], lt);
        access(1'b1, addr, lt, 2'd0, 32'd0);
        assert (got_flags == {mis, unk, 2'b00})
            else fail_value("load flags", {mis, unk, 2'b00}, got_flags);
        if (!mis && !unk)
            assert (got_data == exp) else fail_value("load_data", exp, got_data);
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [1:0] st,
                               input logic [31:0] data);
        logic [3:0]  m;
        logic [31:0] rep;
        logic [31:0] w;
        logic        mis;
        logic        unk;
        unk = st == 2'd3;
        m   = mask_of(addr[1:0], st);
        mis = !unk && m == 4'b0000;
        rep = st == 2'd0 ? {4{data[7:0]}} : (st == 2'd1 ? {2{data[15:0]}} : data);
        access(1'b0, addr, 3'd0, st, data);
        assert (got_flags == {2'b00, mis, unk})
            else fail_value("store flags", {2'b00, mis, unk}, got_flags);
        w = mirror_word(addr);
        for (int b = 0; b < 4; b++)
            if (m[b])
                w[8*b +: 8] = rep[8*b +: 8];
        mirror[{addr[31:2], 2'b00}] = w;
    endtask

    initial begin
        int t;
        address     = '0;
        load        = 1'b0;
        load_type   = LOAD_WORD;
        store       = 1'b0;
        store_type  = STORE_WORD;
        store_data  = '0;
        read_cmds   = 0;
        write_beats = 0;
        t = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            t++;
            if (t > 20)
                timeout_fail("reset release");
        end
        @(negedge clk);
        assert (!busy && !done && !m_read && !m_write)
            else fail_value("busy,done,m_read,m_write", 0, {busy, done, m_read, m_write});

        // Cold miss then a hit in the same line
        r0 = read_cmds;
        check_load(32'h0000_1004, 3'd2);
        assert (read_cmds == r0 + 1) else fail_value("read_cmds", r0 + 1, read_cmds);
        assert (last_read_addr == 32'h0000_1000)
            else fail_value("m_address", 32'h0000_1000, last_read_addr);
        assert (last_read_burst == 4'd8)
            else fail_value("m_burstcount", 8, last_read_burst);
        check_load(32'h0000_1010, 3'd2);
        assert (read_cmds == r0 + 1) else fail_value("read_cmds", r0 + 1, read_cmds);

        // Partial stores, then every load type at every offset
        check_store(32'h0000_1005, 2'd0, 32'h0000_0080);
        check_store(32'h0000_100a, 2'd1, 32'h0000_beef);
        check_store(32'h0000_1008, 2'd0, 32'h0000_007f);
        for (int o = 0; o < 4; o++) begin
            for (int lt = 0; lt < 6; lt++) begin
                if (lt != 3) begin
                    check_load(32'h0000_1004 + o, 3'(lt));
                    check_load(32'h0000_1008 + o, 3'(lt));
                end
            end
        end

        // Third line in lane 0 pushes out the dirty line at 0x1000
        w0 = write_beats;
        check_store(32'h0000_1200, 2'd2, 32'h1111_2222);
        check_store(32'h0000_1400, 2'd2, 32'h3333_4444);
        assert (write_beats == w0 + 8) else fail_value("write_beats", w0 + 8, write_beats);
        for (int i = 0; i < 8; i++)
            assert (mem_i.peek(32'h1000 + 4 * i) == mirror_word(32'h1000 + 4 * i))
                else fail_value("memory word", mirror_word(32'h1000 + 4 * i),
                                mem_i.peek(32'h1000 + 4 * i));
        check_load(32'h0000_1004, 3'd2);
        check_load(32'h0000_1008, 3'd2);

        // Uncached window
        r0 = read_cmds;
        w0 = write_beats;
        check_load(32'h8000_0040, 3'd2);
        assert (read_cmds == r0 + 1) else fail_value("read_cmds", r0 + 1, read_cmds);
        assert (last_read_addr == 32'h8000_0040)
            else fail_value("m_address", 32'h8000_0040, last_read_addr);
        assert (last_read_burst == 4'd1)
            else fail_value("m_burstcount", 1, last_read_burst);
        check_store(32'h8000_0041, 2'd0, 32'h0000_005c);
        // Write beat lands on the edge that closes the done cycle
        @(negedge clk);
        assert (write_beats == w0 + 1) else fail_value("write_beats", w0 + 1, write_beats);
        assert (last_be == 4'b0010) else fail_value("m_byteenable", 4'b0010, last_be);
        assert (mem_i.peek(32'h8000_0040) == mirror_word(32'h8000_0040))
            else fail_value("memory word", mirror_word(32'h8000_0040), mem_i.peek(32'h8000_0040));
        check_load(32'h8000_0041, 3'd4);

        // Bad requests touch nothing
        r0 = read_cmds;
        w0 = write_beats;
        check_load(32'h0000_1001, 3'd1);
        check_load(32'h0000_1002, 3'd2);
        check_load(32'h0000_1000, 3'd3);
        check_load(32'h0000_1000, 3'd6);
        check_store(32'h0000_1001, 2'd2, 32'hdead_beef);
        check_store(32'h0000_1003, 2'd1, 32'hdead_beef);
        check_store(32'h0000_1000, 2'd3, 32'hdead_beef);
        assert (read_cmds == r0) else fail_value("read_cmds", r0, read_cmds);
        assert (write_beats == w0) else fail_value("write_beats", w0, write_beats);
        check_load(32'h0000_1000, 3'd2);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire [31:0]  m_address,
    input  wire [3:0]   m_burstcount,
    input  wire         m_read,
    input  wire         m_write,
    input  wire [31:0]  m_writedata,
    input  wire [3:0]   m_byteenable,
    output logic        m_waitrequest,
    output logic [31:0] m_readdata,
    output logic        m_readdatavalid
);
    logic [31:0] mem [logic [31:0]];
    integer      seed = 95702;
    logic [31:0] rd_addr;
    logic [3:0]  rd_left;
    logic [3:0]  wr_beat;

    // Untouched words follow the address rule
    function automatic logic [31:0] peek(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'h5A5A_0000;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_waitrequest   <= 1'b0;
            m_readdata      <= '0;
            m_readdatavalid <= 1'b0;
            rd_left         <= '0;
            wr_beat         <= '0;
        end else begin
            m_waitrequest <= ($random(seed) & 3) == 0;
            if (m_read && !m_waitrequest) begin
                rd_addr <= {m_address[31:2], 2'b00};
                rd_left <= m_burstcount;
            end
            // Data beats come back with random gaps
            m_readdatavalid <= 1'b0;
            if (rd_left != 0 && ($random(seed) & 3) != 0) begin
                m_readdatavalid <= 1'b1;
                m_readdata      <= peek(rd_addr);
                rd_addr         <= rd_addr + 32'd4;
                rd_left         <= rd_left - 1'b1;
            end
            if (m_write && !m_waitrequest) begin
                logic [31:0] a;
                logic [31:0] w;
                a = {m_address[31:2], 2'b00} + {wr_beat, 2'b00};
                w = peek(a);
                for (int b = 0; b < 4; b++)
                    if (m_byteenable[b])
                        w[8*b +: 8] = m_writedata[8*b +: 8];
                mem[a] = w;
                if (wr_beat + 1'b1 >= m_burstcount)
                    wr_beat <= '0;
                else
                    wr_beat <= wr_beat + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial clk = 1'b0;

    always #50 clk = ~clk;

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/dcache.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"
`default_nettype none

module dcache (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [31:0]                   address,
    input  wire                          load,
    input  wire cache_pkg::load_type_t   load_type,
    input  wire                          store,
    input  wire cache_pkg::store_type_t  store_type,
    input  wire [31:0]                   store_data,
    output logic                         busy,
    output logic                         done,
    output logic [31:0]                  load_data,
    output logic                         load_misaligned,
    output logic                         load_unknown_type,
    output logic                         store_misaligned,
    output logic                         store_unknown_type,
    output logic [31:0]                  m_address,
    output logic [`CACHE_OFFSET_W:0]     m_burstcount,
    output logic                         m_read,
    output logic                         m_write,
    output logic [31:0]                  m_writedata,
    output logic [3:0]                   m_byteenable,
    input  wire                          m_waitrequest,
    input  wire [31:0]                   m_readdata,
    input  wire                          m_readdatavalid
);
    import cache_pkg::*;

    logic                        hit;
    logic [`CACHE_WAYS_W-1:0]    hit_way;
    logic [31:0]                 hit_data;
    logic [31:0]                 victim_data;
    logic [`CACHE_TAG_W-1:0]     victim_tag;
    logic                        victim_valid;
    logic                        victim_dirty;
    logic [31:0]                 store_word;
    logic [3:0]                  store_mask;
    logic [1:0]                  req_in_word;
    load_type_t                  req_load_type;
    store_type_t                 req_store_type;
    logic [31:0]                 req_store_data;
    logic [31:0]                 load_source_data;
    logic                        read_en;
    logic [`CACHE_LANES_W-1:0]   read_lane;
    logic [`CACHE_OFFSET_W-1:0]  read_offset;
    logic [`CACHE_TAG_W-1:0]     lookup_tag;
    logic [`CACHE_WAYS_W-1:0]    victim_way;
    logic                        write_en;
    logic [`CACHE_WAYS_W-1:0]    write_way;
    logic [`CACHE_LANES_W-1:0]   write_lane;
    logic [`CACHE_OFFSET_W-1:0]  write_offset;
    logic [31:0]                 write_data;
    logic                        write_dirty;
    logic                        line_fill;

    cache_ctrl ctrl_i (
        .*,
        .load_bad  (load_misaligned || load_unknown_type),
        .store_bad (store_misaligned || store_unknown_type)
    );

    cache_ways ways_i (.*);

    // Aligners work on the request held in the output stage
    load_align load_align_i (
        .in_word      (req_in_word),
        .load_type    (req_load_type),
        .data_in      (load_source_data),
        .data_out     (load_data),
        .misaligned   (load_misaligned),
        .unknown_type (load_unknown_type)
    );

    store_align store_align_i (
        .in_word      (req_in_word),
        .store_type   (req_store_type),
        .data_in      (req_store_data),
        .data_out     (store_word),
        .mask         (store_mask),
        .misaligned   (store_misaligned),
        .unknown_type (store_unknown_type)
    );

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"
`default_nettype none

module cache_ctrl (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [31:0]                   address,
    input  wire                          load,
    input  wire cache_pkg::load_type_t   load_type,
    input  wire                          store,
    input  wire cache_pkg::store_type_t  store_type,
    input  wire [31:0]                   store_data,
    input  wire                          m_waitrequest,
    input  wire [31:0]                   m_readdata,
    input  wire                          m_readdatavalid,
    input  wire                          hit,
    input  wire [`CACHE_WAYS_W-1:0]      hit_way,
    input  wire [31:0]                   hit_data,
    input  wire [31:0]                   victim_data,
    input  wire [`CACHE_TAG_W-1:0]       victim_tag,
    input  wire                          victim_valid,
    input  wire                          victim_dirty,
    input  wire [31:0]                   store_word,
    input  wire [3:0]                    store_mask,
    input  wire                          store_bad,
    input  wire                          load_bad,
    output logic                         busy,
    output logic                         done,
    output logic [1:0]                   req_in_word,
    output cache_pkg::load_type_t        req_load_type,
    output cache_pkg::store_type_t       req_store_type,
    output logic [31:0]                  req_store_data,
    output logic [31:0]                  load_source_data,
    output logic [31:0]                  m_address,
    output logic [`CACHE_OFFSET_W:0]     m_burstcount,
    output logic                         m_read,
    output logic                         m_write,
    output logic [31:0]                  m_writedata,
    output logic [3:0]                   m_byteenable,
    output logic                         read_en,
    output logic [`CACHE_LANES_W-1:0]    read_lane,
    output logic [`CACHE_OFFSET_W-1:0]   read_offset,
    output logic [`CACHE_TAG_W-1:0]      lookup_tag,
    output logic [`CACHE_WAYS_W-1:0]     victim_way,
    output logic                         write_en,
    output logic [`CACHE_WAYS_W-1:0]     write_way,
    output logic [`CACHE_LANES_W-1:0]    write_lane,
    output logic [`CACHE_OFFSET_W-1:0]   write_offset,
    output logic [31:0]                  write_data,
    output logic                         write_dirty,
    output logic                         line_fill
);
    import cache_pkg::*;

    cache_state_t                state;
    logic                        os_active;
    logic                        replay;
    logic                        read_acked;
    logic                        req_load;
    logic                        req_uncached;
    logic [`CACHE_LANES_W-1:0]   req_lane;
    logic [`CACHE_OFFSET_W-1:0]  req_offset;
    logic [`CACHE_OFFSET_W-1:0]  word_cnt;
    logic                        accept;
    logic                        bad;
    logic                        lookup;
    logic                        miss;
    logic [31:0]                 merged;

    assign bad    = req_load ? load_bad : store_bad;
    // Cached request in the output stage that passed the type checks
    assign lookup = state == IDLE && os_active && !bad && !req_uncached;
    assign miss   = lookup && !hit;
    assign accept = (load || store) && !busy;

    always_comb begin
        busy = 1'b1;
        done = 1'b0;
        case (state)
            IDLE: begin
                busy = replay || (os_active && !bad && (req_uncached || !hit || !req_load));
                done = os_active && (bad || (!req_uncached && hit));
            end
            BYPASS: done = req_load ? m_readdatavalid : !m_waitrequest;
            default: ;
        endcase
    end

    // Store bytes over the line word
    always_comb begin
        for (int b = 0; b < 4; b++)
            merged[8*b +: 8] = store_mask[b] ? store_word[8*b +: 8] : hit_data[8*b +: 8];
    end

    always_comb begin
        read_en     = accept;
        read_lane   = address[2+`CACHE_OFFSET_W +: `CACHE_LANES_W];
        read_offset = address[2 +: `CACHE_OFFSET_W];
        if (replay) begin
            read_en     = 1'b1;
            read_lane   = req_lane;
            read_offset = req_offset;
        end else if (miss) begin
            read_en     = 1'b1;
            read_lane   = req_lane;
            read_offset = '0;
        end else if (state == WRITEBACK) begin
            // Fetch the next victim word once the current one is taken
            read_en     = !m_waitrequest;
            read_lane   = req_lane;
            read_offset = word_cnt + 1'b1;
        end
    end

    assign write_lane = req_lane;

    always_comb begin
        if (state == REFILL) begin
            write_en     = m_readdatavalid;
            write_way    = victim_way;
            write_offset = word_cnt;
            write_data   = m_readdata;
            write_dirty  = 1'b0;
            line_fill    = m_readdatavalid && word_cnt == '0;
        end else begin
            write_en     = lookup && hit && !req_load;
            write_way    = hit_way;
            write_offset = req_offset;
            write_data   = merged;
            write_dirty  = 1'b1;
            line_fill    = 1'b0;
        end
    end

    always_comb begin
        m_address    = {lookup_tag, req_lane, {`CACHE_OFFSET_W{1'b0}}, 2'b00};
        m_burstcount = {1'b1, {`CACHE_OFFSET_W{1'b0}}};
        m_read       = 1'b0;
        m_write      = 1'b0;
        m_writedata  = victim_data;
        m_byteenable = 4'b1111;
        case (state)
            WRITEBACK: begin
                m_address = {victim_tag, req_lane, {`CACHE_OFFSET_W{1'b0}}, 2'b00};
                m_write   = 1'b1;
            end
            REFILL: m_read = !read_acked;
            BYPASS: begin
                m_address    = {lookup_tag, req_lane, req_offset, 2'b00};
                m_burstcount = (`CACHE_OFFSET_W+1)'(1);
                m_read       = req_load && !read_acked;
                m_write      = !req_load;
                m_writedata  = store_word;
                m_byteenable = req_load ? 4'b1111 : store_mask;
            end
            default: ;
        endcase
    end

    assign load_source_data = state == BYPASS ? m_readdata : hit_data;

    always_ff @(posedge clk) begin
        if (accept) begin
            lookup_tag     <= address[31 -: `CACHE_TAG_W];
            req_lane       <= address[2+`CACHE_OFFSET_W +: `CACHE_LANES_W];
            req_offset     <= address[2 +: `CACHE_OFFSET_W];
            req_in_word    <= address[1:0];
            req_load       <= load;
            req_uncached   <= address[`CACHE_UNCACHED_BIT];
            // Byte type on the unused side never raises a flag
            req_load_type  <= load ? load_type : LOAD_BYTE;
            req_store_type <= load ? STORE_BYTE : store_type;
            req_store_data <= store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            os_active  <= 1'b0;
            replay     <= 1'b0;
            read_acked <= 1'b0;
            word_cnt   <= '0;
            victim_way <= '0;
        end else begin
            case (state)
                IDLE: begin
                    os_active <= accept || replay;
                    replay    <= 1'b0;
                    if (os_active && !bad && req_uncached)
                        state <= BYPASS;
                    else if (miss)
                        state <= (victim_valid && victim_dirty) ? WRITEBACK : REFILL;
                end
                WRITEBACK: begin
                    if (!m_waitrequest) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (&word_cnt)
                            state <= REFILL;
                    end
                end
                REFILL: begin
                    if (m_read && !m_waitrequest)
                        read_acked <= 1'b1;
                    if (m_readdatavalid) begin
                        word_cnt <= word_cnt + 1'b1;
                        // Last word in, so look the request up again
                        if (&word_cnt) begin
                            state      <= IDLE;
                            replay     <= 1'b1;
                            read_acked <= 1'b0;
                            victim_way <= victim_way + 1'b1;
                        end
                    end
                end
                BYPASS: begin
                    if (m_read && !m_waitrequest)
                        read_acked <= 1'b1;
                    if (done) begin
                        state      <= IDLE;
                        read_acked <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_ways.sv ====
`timescale 1ns/10ps
`include "cache_config.svh"
`default_nettype none

module cache_ways (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         read_en,
    input  wire [`CACHE_LANES_W-1:0]    read_lane,
    input  wire [`CACHE_OFFSET_W-1:0]   read_offset,
    input  wire [`CACHE_TAG_W-1:0]      lookup_tag,
    input  wire [`CACHE_WAYS_W-1:0]     victim_way,
    input  wire                         write_en,
    input  wire [`CACHE_WAYS_W-1:0]     write_way,
    input  wire [`CACHE_LANES_W-1:0]    write_lane,
    input  wire [`CACHE_OFFSET_W-1:0]   write_offset,
    input  wire [31:0]                  write_data,
    input  wire                         write_dirty,
    input  wire                         line_fill,
    output logic                        hit,
    output logic [`CACHE_WAYS_W-1:0]    hit_way,
    output logic [31:0]                 hit_data,
    output logic [31:0]                 victim_data,
    output logic [`CACHE_TAG_W-1:0]     victim_tag,
    output logic                        victim_valid,
    output logic                        victim_dirty
);
    localparam int WAYS  = 1 << `CACHE_WAYS_W;
    localparam int LANES = 1 << `CACHE_LANES_W;
    localparam int WORDS = 1 << `CACHE_OFFSET_W;

    logic [31:0]               data_mem [WAYS][LANES*WORDS];
    logic [`CACHE_TAG_W-1:0]   tag_mem  [WAYS][LANES];
    logic [WAYS-1:0]           valid    [LANES];
    logic [WAYS-1:0]           dirty    [LANES];
    logic [31:0]               rd_data  [WAYS];
    logic [`CACHE_TAG_W-1:0]   rd_tag   [WAYS];
    logic [`CACHE_LANES_W-1:0] lane_q;

    // One read port, used by lookups and by the write-back walk
    always_ff @(posedge clk) begin
        if (read_en) begin
            lane_q <= read_lane;
            for (int w = 0; w < WAYS; w++) begin
                rd_data[w] <= data_mem[w][{read_lane, read_offset}];
                rd_tag[w]  <= tag_mem[w][read_lane];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            data_mem[write_way][{write_lane, write_offset}] <= write_data;
            // Tag of a new line is the tag being looked up
            if (line_fill)
                tag_mem[write_way][write_lane] <= lookup_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < LANES; l++) begin
                valid[l] <= '0;
                dirty[l] <= '0;
            end
        end else if (write_en) begin
            if (line_fill) begin
                valid[write_lane][write_way] <= 1'b1;
                dirty[write_lane][write_way] <= 1'b0;
            end else if (write_dirty) begin
                dirty[write_lane][write_way] <= 1'b1;
            end
        end
    end

    // Tag compare across all ways of the registered lane
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_data = rd_data[0];
        for (int w = 0; w < WAYS; w++) begin
            if (valid[lane_q][w] && rd_tag[w] == lookup_tag) begin
                hit      = 1'b1;
                hit_way  = `CACHE_WAYS_W'(w);
                hit_data = rd_data[w];
            end
        end
    end

    assign victim_data  = rd_data[victim_way];
    assign victim_tag   = rd_tag[victim_way];
    assign victim_valid = valid[lane_q][victim_way];
    assign victim_dirty = dirty[lane_q][victim_way];

endmodule

`default_nettype wire

// ==== hdl/store_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_align (
    input  wire [1:0]                    in_word,
    input  wire cache_pkg::store_type_t  store_type,
    input  wire [31:0]                   data_in,
    output logic [31:0]                  data_out,
    output logic [3:0]                   mask,
    output logic                         misaligned,
    output logic                         unknown_type
);
    import cache_pkg::*;

    always_comb begin
        data_out     = data_in;
        mask         = 4'b0000;
        misaligned   = 1'b0;
        unknown_type = 1'b0;
        case (store_type)
            STORE_BYTE: begin
                data_out = {4{data_in[7:0]}};
                mask     = 4'b0001 << in_word;
            end
            STORE_HALF: begin
                data_out   = {2{data_in[15:0]}};
                misaligned = in_word[0];
                if (!in_word[0])
                    mask = in_word[1] ? 4'b1100 : 4'b0011;
            end
            STORE_WORD: begin
                misaligned = |in_word;
                if (in_word == 2'b00)
                    mask = 4'b1111;
            end
            default: begin
                unknown_type = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  wire [1:0]                   in_word,
    input  wire cache_pkg::load_type_t  load_type,
    input  wire [31:0]                  data_in,
    output logic [31:0]                 data_out,
    output logic                        misaligned,
    output logic                        unknown_type
);
    import cache_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Addressed byte and half of the word
    assign sel_byte = data_in[{in_word, 3'b000} +: 8];
    assign sel_half = in_word[1] ? data_in[31:16] : data_in[15:0];

    always_comb begin
        data_out     = data_in;
        misaligned   = 1'b0;
        unknown_type = 1'b0;
        case (load_type)
            LOAD_BYTE: begin
                data_out = {{24{sel_byte[7]}}, sel_byte};
            end
            LOAD_BYTE_U: begin
                data_out = {24'h000000, sel_byte};
            end
            LOAD_HALF: begin
                data_out   = {{16{sel_half[15]}}, sel_half};
                misaligned = in_word[0];
            end
            LOAD_HALF_U: begin
                data_out   = {16'h0000, sel_half};
                misaligned = in_word[0];
            end
            LOAD_WORD: begin
                misaligned = |in_word;
            end
            default: begin
                unknown_type = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // IDLE also serves as the output stage
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        BYPASS
    } cache_state_t;

    // Codes 3, 6 and 7 are unknown
    typedef enum logic [2:0] {
        LOAD_BYTE   = 3'd0,
        LOAD_HALF   = 3'd1,
        LOAD_WORD   = 3'd2,
        LOAD_BYTE_U = 3'd4,
        LOAD_HALF_U = 3'd5
    } load_type_t;

    // Code 3 is unknown
    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_type_t;

endpackage

`default_nettype wire

// ==== hdl/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Number of ways as a power of two
`define CACHE_WAYS_W 1

// Lanes (sets) per way as a power of two
`define CACHE_LANES_W 4

// Words per line as a power of two
`define CACHE_OFFSET_W 3

// Physical tag is everything above the lane field
`define CACHE_TAG_W (32 - 2 - `CACHE_OFFSET_W - `CACHE_LANES_W)

// Addresses with this bit set skip the cache
`define CACHE_UNCACHED_BIT 31

`endif
